// ==== uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Bits per character
`define UART_DATA_W 8

// Clock cycles per serial bit
// Kept short so simulation runs fast
`define UART_CYCLES_PER_BIT 16

// Transmit FIFO depth, power of two only
`define UART_FIFO_DEPTH 8

`endif

// ==== uart_pkg.sv ====
`include "uart_params.svh"

package uart_pkg;

    // One character on the line
    typedef logic [`UART_DATA_W-1:0] uart_byte_t;

    // Bit-period counter, holds values up to the cycles per bit
    typedef logic [$clog2(`UART_CYCLES_PER_BIT + 1)-1:0] baud_cnt_t;

    // Index of the data bit within a frame
    typedef logic [2:0] bit_idx_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];

    // Extra top bit tells full from empty when addresses match
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                   (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[AW-1:0]];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr[AW-1:0]] <= in_data;
        end
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uart_pkg::uart_byte_t data,
    input  logic                 valid,
    output logic                 ready,
    output logic                 tx,
    output logic                 busy
);

    localparam uart_pkg::baud_cnt_t BIT_LAST =
        uart_pkg::baud_cnt_t'(`UART_CYCLES_PER_BIT - 1);

    // Stop state is one cycle short, the idle cycle holding
    // the line high finishes the stop bit
    localparam uart_pkg::baud_cnt_t STOP_LAST =
        uart_pkg::baud_cnt_t'(`UART_CYCLES_PER_BIT - 2);

    localparam uart_pkg::bit_idx_t IDX_LAST =
        uart_pkg::bit_idx_t'(`UART_DATA_W - 1);

    uart_pkg::tx_state_t  state;
    uart_pkg::baud_cnt_t  baud_cnt;
    uart_pkg::bit_idx_t   bit_idx;
    uart_pkg::uart_byte_t shift_reg;
    logic                 tx_q;
    logic                 bit_end;

    assign bit_end = (baud_cnt == BIT_LAST);

    assign ready = (state == uart_pkg::TX_IDLE);
    assign busy  = (state != uart_pkg::TX_IDLE);
    assign tx    = tx_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= uart_pkg::TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx_q     <= 1'b1;
        end
        else
        begin
            case (state)
                uart_pkg::TX_IDLE:
                begin
                    // Line drops on the cycle after the pop
                    if (valid)
                    begin
                        state    <= uart_pkg::TX_START;
                        baud_cnt <= '0;
                        tx_q     <= 1'b0;
                    end
                end
                uart_pkg::TX_START:
                begin
                    if (bit_end)
                    begin
                        state    <= uart_pkg::TX_DATA;
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        tx_q     <= shift_reg[0];
                    end
                    else
                    begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::TX_DATA:
                begin
                    if (bit_end)
                    begin
                        baud_cnt <= '0;
                        if (bit_idx == IDX_LAST)
                        begin
                            state <= uart_pkg::TX_STOP;
                            tx_q  <= 1'b1;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_q    <= shift_reg[1];
                        end
                    end
                    else
                    begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::TX_STOP:
                begin
                    if (baud_cnt == STOP_LAST)
                    begin
                        state <= uart_pkg::TX_IDLE;
                    end
                    else
                    begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default:
                begin
                    state <= uart_pkg::TX_IDLE;
                    tx_q  <= 1'b1;
                end
            endcase
        end
    end

    // LSB of the shift register is always the bit on the line
    always_ff @(posedge clk)
    begin
        if (ready && valid)
        begin
            shift_reg <= data;
        end
        else if (state == uart_pkg::TX_DATA && bit_end)
        begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rx,
    output uart_pkg::uart_byte_t data,
    output logic                 valid,
    output logic                 frame_err
);

    localparam uart_pkg::baud_cnt_t BIT_LAST =
        uart_pkg::baud_cnt_t'(`UART_CYCLES_PER_BIT - 1);

    localparam uart_pkg::baud_cnt_t HALF_LAST =
        uart_pkg::baud_cnt_t'(`UART_CYCLES_PER_BIT / 2 - 1);

    localparam uart_pkg::bit_idx_t IDX_LAST =
        uart_pkg::bit_idx_t'(`UART_DATA_W - 1);

    uart_pkg::rx_state_t  state;
    uart_pkg::baud_cnt_t  baud_cnt;
    uart_pkg::bit_idx_t   bit_idx;
    uart_pkg::uart_byte_t shift_reg;

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic valid_q;
    logic frame_err_q;
    logic fall;

    // Idle line is high
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = rx_prev && !rx_sync;

    assign data      = shift_reg;
    assign valid     = valid_q;
    assign frame_err = frame_err_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state       <= uart_pkg::RX_IDLE;
            baud_cnt    <= '0;
            bit_idx     <= '0;
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
        end
        else
        begin
            valid_q     <= 1'b0;
            frame_err_q <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE:
                begin
                    if (fall)
                    begin
                        state    <= uart_pkg::RX_START;
                        baud_cnt <= '0;
                    end
                end
                uart_pkg::RX_START:
                begin
                    // Half a bit in, line must still be low
                    if (baud_cnt == HALF_LAST)
                    begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        if (rx_sync)
                        begin
                            state <= uart_pkg::RX_IDLE;
                        end
                        else
                        begin
                            state <= uart_pkg::RX_DATA;
                        end
                    end
                    else
                    begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_DATA:
                begin
                    if (baud_cnt == BIT_LAST)
                    begin
                        baud_cnt <= '0;
                        if (bit_idx == IDX_LAST)
                        begin
                            state <= uart_pkg::RX_STOP;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                    else
                    begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_STOP:
                begin
                    if (baud_cnt == BIT_LAST)
                    begin
                        state       <= uart_pkg::RX_IDLE;
                        baud_cnt    <= '0;
                        valid_q     <= rx_sync;
                        frame_err_q <= !rx_sync;
                    end
                    else
                    begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default:
                begin
                    state <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Bits arrive LSB first, so shift in from the top
    always_ff @(posedge clk)
    begin
        if (state == uart_pkg::RX_DATA && baud_cnt == BIT_LAST)
        begin
            shift_reg <= {rx_sync, shift_reg[`UART_DATA_W-1:1]};
        end
    end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  uart_pkg::uart_byte_t in_data,
    input  logic                 in_valid,
    output logic                 in_ready,
    output logic                 tx,
    output logic                 tx_busy,
    input  logic                 rx,
    output uart_pkg::uart_byte_t rx_data,
    output logic                 rx_valid,
    output logic                 rx_frame_err
);

    uart_pkg::uart_byte_t fifo_data;
    logic                 fifo_valid;
    logic                 fifo_ready;

    // Transmit buffer between host and serializer
    sync_fifo #(
        .DEPTH (`UART_FIFO_DEPTH),
        .WIDTH (`UART_DATA_W)
    ) sync_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    uart_tx uart_tx_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .data  (fifo_data),
        .valid (fifo_valid),
        .ready (fifo_ready),
        .tx    (tx),
        .busy  (tx_busy)
    );

    // Receive path is independent of the transmit chain
    uart_rx uart_rx_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .data      (rx_data),
        .valid     (rx_valid),
        .frame_err (rx_frame_err)
    );

endmodule

// ==== tb_uart.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_uart;

    localparam int N            = `UART_CYCLES_PER_BIT;
    localparam int DEPTH        = `UART_FIFO_DEPTH;
    localparam int RESET_CYCLES = 5;
    localparam int FRAME_CYCLES = 10 * N;
    // Frames sent by all tests, plus room for gaps and idle waits
    localparam int RUN_FRAMES   = 1 + 10 + (DEPTH + 2) + 1 + 3;
    localparam int LIMIT        = RUN_FRAMES * FRAME_CYCLES * 6 / 5 + RESET_CYCLES;
    // Samples with in_ready low once the FIFO fills behind the first frame
    localparam int FULL_LOW     = FRAME_CYCLES + 1 - DEPTH;

    logic                 clk = 1'b0;
    logic                 rst_n;
    uart_pkg::uart_byte_t in_data;
    logic                 in_valid;
    logic                 in_ready;
    logic                 tx;
    logic                 tx_busy;
    logic                 rx_line;
    uart_pkg::uart_byte_t rx_data;
    logic                 rx_valid;
    logic                 rx_frame_err;

    // Receiver input is either the looped back tx or a line driven here
    logic line_sel;
    logic drv_line;

    uart_pkg::uart_byte_t exp_q[$];
    uart_pkg::uart_byte_t exp_byte;
    uart_pkg::uart_byte_t first_byte;

    string cur_test;
    int    err_cnt = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    int    test_err_start;
    int    cycle_cnt = 0;
    int    rx_valid_cnt = 0;
    int    frame_err_cnt = 0;
    int    valid_before;
    int    ferr_before;
    int    low_cycles;
    int    gap;

    assign rx_line = line_sel ? drv_line : tx;

    uart_top uart_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .tx           (tx),
        .tx_busy      (tx_busy),
        .rx           (rx_line),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_frame_err (rx_frame_err)
    );

    always #2 clk = ~clk;

    task automatic note_error(input string msg);
        $display("error in %s: %s", cur_test, msg);
        err_cnt++;
    endtask

    task automatic note_mismatch(input string test, input int exp, input int act);
        $display("ERR %s expected 0x%0h actual 0x%0h", test, exp, act);
        err_cnt++;
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == test_err_start)
        begin
            pass_cnt++;
            $display("test %s: ok", cur_test);
        end
        else
        begin
            fail_cnt++;
            $display("test %s: %0d errors", cur_test, err_cnt - test_err_start);
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic push_byte(input uart_pkg::uart_byte_t b);
        in_data  = b;
        in_valid = 1'b1;
        while (!in_ready)
        begin
            @(negedge clk);
        end
        exp_q.push_back(b);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        do
        begin
            @(negedge clk);
        end
        while (exp_q.size() != 0 || tx_busy);
        repeat (N) @(negedge clk);
    endtask

    task automatic check_frame(input uart_pkg::uart_byte_t b);
        logic exp_bit;
        int   slot;
        // Pop lands one cycle after the push, line drops the cycle after
        assert (tx === 1'b1) else note_mismatch(cur_test, 1, 32'(tx));
        @(negedge clk);
        for (int k = 0; k < FRAME_CYCLES; k++)
        begin
            slot = k / N;
            if (slot == 0)
                exp_bit = 1'b0;
            else if (slot == 9)
                exp_bit = 1'b1;
            else
                exp_bit = b[slot - 1];
            assert (tx === exp_bit) else note_mismatch(cur_test, 32'(exp_bit), 32'(tx));
            @(negedge clk);
        end
        assert (tx === 1'b1) else note_mismatch(cur_test, 1, 32'(tx));
    endtask

    task automatic drive_frame(input uart_pkg::uart_byte_t b, input logic stop);
        drv_line = 1'b0;
        repeat (N) @(negedge clk);
        for (int i = 0; i < `UART_DATA_W; i++)
        begin
            drv_line = b[i];
            repeat (N) @(negedge clk);
        end
        drv_line = stop;
        repeat (N) @(negedge clk);
        drv_line = 1'b1;
    endtask

    // Receive scoreboard
    always @(negedge clk)
    begin
        if (rst_n && rx_valid)
        begin
            rx_valid_cnt++;
            if (exp_q.size() == 0)
            begin
                note_error("rx_valid pulsed with no byte outstanding");
            end
            else
            begin
                exp_byte = exp_q.pop_front();
                assert (rx_data == exp_byte)
                    else note_mismatch(cur_test, 32'(exp_byte), 32'(rx_data));
            end
        end
        if (rst_n && rx_frame_err)
        begin
            frame_err_cnt++;
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
        else note_error("tx low while the transmitter is idle");

    initial
    begin
        void'($urandom(32'h5bcb190b));
        rst_n    = 1'b0;
        in_data  = '0;
        in_valid = 1'b0;
        drv_line = 1'b1;
        line_sel = 1'b0;
        cur_test = "reset";
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_state");
        assert (tx === 1'b1) else note_mismatch(cur_test, 1, 32'(tx));
        assert (tx_busy === 1'b0) else note_mismatch(cur_test, 0, 32'(tx_busy));
        assert (in_ready === 1'b1) else note_mismatch(cur_test, 1, 32'(in_ready));
        repeat (2 * N)
        begin
            @(negedge clk);
            assert (tx === 1'b1) else note_mismatch(cur_test, 1, 32'(tx));
        end
        finish_test();

        start_test("frame_timing");
        first_byte = uart_pkg::uart_byte_t'($urandom);
        push_byte(first_byte);
        check_frame(first_byte);
        wait_drain();
        finish_test();

        start_test("loopback");
        valid_before = rx_valid_cnt;
        ferr_before  = frame_err_cnt;
        for (int i = 0; i < 10; i++)
        begin
            gap = $urandom_range(0, 12);
            repeat (gap) @(negedge clk);
            push_byte(uart_pkg::uart_byte_t'($urandom));
        end
        wait_drain();
        assert (rx_valid_cnt - valid_before == 10)
            else note_mismatch(cur_test, 10, rx_valid_cnt - valid_before);
        assert (frame_err_cnt == ferr_before)
            else note_mismatch(cur_test, 0, frame_err_cnt - ferr_before);
        finish_test();

        start_test("back_pressure");
        valid_before = rx_valid_cnt;
        ferr_before  = frame_err_cnt;
        // First byte goes straight to the transmitter, the rest fill the FIFO
        for (int i = 0; i <= DEPTH; i++)
        begin
            push_byte(uart_pkg::uart_byte_t'($urandom));
        end
        assert (in_ready === 1'b0) else note_mismatch(cur_test, 0, 32'(in_ready));
        in_data    = uart_pkg::uart_byte_t'($urandom);
        in_valid   = 1'b1;
        low_cycles = 0;
        while (!in_ready)
        begin
            low_cycles++;
            @(negedge clk);
        end
        exp_q.push_back(in_data);
        @(negedge clk);
        in_valid = 1'b0;
        assert (low_cycles == FULL_LOW) else note_mismatch(cur_test, FULL_LOW, low_cycles);
        wait_drain();
        assert (rx_valid_cnt - valid_before == DEPTH + 2)
            else note_mismatch(cur_test, DEPTH + 2, rx_valid_cnt - valid_before);
        assert (frame_err_cnt == ferr_before)
            else note_mismatch(cur_test, 0, frame_err_cnt - ferr_before);
        finish_test();

        start_test("framing_error");
        drv_line = 1'b1;
        line_sel = 1'b1;
        repeat (4) @(negedge clk);
        valid_before = rx_valid_cnt;
        ferr_before  = frame_err_cnt;
        drive_frame(uart_pkg::uart_byte_t'($urandom), 1'b0);
        repeat (N) @(negedge clk);
        assert (frame_err_cnt - ferr_before == 1)
            else note_mismatch(cur_test, 1, frame_err_cnt - ferr_before);
        assert (rx_valid_cnt == valid_before)
            else note_mismatch(cur_test, 0, rx_valid_cnt - valid_before);
        finish_test();

        start_test("false_start");
        valid_before = rx_valid_cnt;
        ferr_before  = frame_err_cnt;
        drv_line = 1'b0;
        repeat (N / 4) @(negedge clk);
        drv_line = 1'b1;
        repeat (FRAME_CYCLES + N) @(negedge clk);
        assert (frame_err_cnt == ferr_before)
            else note_mismatch(cur_test, 0, frame_err_cnt - ferr_before);
        assert (rx_valid_cnt == valid_before)
            else note_mismatch(cur_test, 0, rx_valid_cnt - valid_before);
        line_sel = 1'b0;
        finish_test();

        $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
uart_pkg.sv
sync_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart.sv

// ==== Makefile ====
# Verilator simulation of the UART testbench

VERILATOR ?= verilator
TOP       ?= tb_uart
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** PASSED ***' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
